/* verilog/soc_settings.svh */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// bus widths
`define ARCHBITSZ 32
`define ADDRBITSZ 30

// reset counter, all ones on reload
`define RST_CNTR_BITSZ 4

// map sizes in bytes, slaves in address order
`define DEVTBL_MAPSZ  32'h100
`define INTCTRL_MAPSZ 32'h100
`define INVALID_MAPSZ 32'h1000

// ids reported by the device table
`define DEVTBL_ID  7
`define INTCTRL_ID 3
`define INVALID_ID 0

// none of the remaining slaves raises interrupts
`define DEVTBL_USEINTR  1'b0
`define INTCTRL_USEINTR 1'b0
`define INVALID_USEINTR 1'b0

`define SOC_DEVCOUNT 3
`define INTSRCCOUNT  3

// device table word offsets
`define DEVTBL_CTRL_WORD  0
`define DEVTBL_COUNT_WORD 1
`define DEVTBL_ENTRY_WORD 2

// interrupt controller word offsets and claim value when idle
`define INTCTRL_CLAIM_WORD 0
`define INTCTRL_NONE       {`ARCHBITSZ{1'b1}}

`endif

/* verilog/pi1_pkg.sv */
`include "soc_settings.svh"

package pi1_pkg;

	// pi1 op encoding as seen on the bus
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR  = 2'b01,
		PI1_RD  = 2'b10,
		PI1_RW  = 2'b11
	} pi1_op_e;

	// slaves in address order, invalid device catches the rest
	typedef enum logic [1:0] {
		SLV_DEVTBL  = 2'd0,
		SLV_INTCTRL = 2'd1,
		SLV_INVALID = 2'd2
	} slave_e;

	typedef logic [`ARCHBITSZ-1:0]     word_t;
	typedef logic [`ADDRBITSZ-1:0]     waddr_t;
	typedef logic [(`ARCHBITSZ/8)-1:0] sel_t;

	// word offset inside the smallest slave window
	typedef logic [$clog2(`DEVTBL_MAPSZ/(`ARCHBITSZ/8))-1:0] offset_t;

endpackage

/* verilog/soc_pkg.sv */
`include "soc_settings.svh"

package soc_pkg;

	// interrupt delivery towards the single destination
	typedef enum logic [1:0] {
		INTC_IDLE       = 2'd0,
		INTC_DELIVER    = 2'd1,
		INTC_WAIT_CLAIM = 2'd2
	} intc_state_e;

	// one bit per source; numbering is 0 sd card, 1 dma, 2 uart
	typedef logic [`INTSRCCOUNT-1:0] intsrc_t;

endpackage

/* verilog/pi1_decoder.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module pi1_decoder (
	 input  logic              clk120mhz
	,input  logic              rst_i
	,input  pi1_pkg::pi1_op_e  pi1_op_i
	,input  pi1_pkg::waddr_t   pi1_addr_i
	,input  pi1_pkg::word_t    pi1_data_i
	,input  pi1_pkg::sel_t     pi1_sel_i
	,output logic              pi1_rdy_o
	,output logic              stg_valid_o
	,output pi1_pkg::pi1_op_e  stg_op_o
	,output pi1_pkg::slave_e   stg_slave_o
	,output pi1_pkg::offset_t  stg_offset_o
	,output pi1_pkg::word_t    stg_data_o
	,output pi1_pkg::sel_t     stg_sel_o
);

// word bases, each the running sum of the byte map sizes before it
localparam pi1_pkg::waddr_t DEVTBL_WBASE  = '0;
localparam pi1_pkg::waddr_t INTCTRL_WBASE =
	pi1_pkg::waddr_t'(`DEVTBL_MAPSZ / (`ARCHBITSZ/8));
localparam pi1_pkg::waddr_t INVALID_WBASE =
	pi1_pkg::waddr_t'((`DEVTBL_MAPSZ + `INTCTRL_MAPSZ) / (`ARCHBITSZ/8));

logic             busy;
logic             accept;
pi1_pkg::slave_e  dec_slave;
pi1_pkg::waddr_t  rel_addr;

assign pi1_rdy_o   = ~busy;
assign stg_valid_o = busy;
assign accept      = pi1_rdy_o && (pi1_op_i != pi1_pkg::PI1_NOP);

// everything at or past the invalid base goes to the default slave
always_comb begin
	dec_slave = pi1_pkg::SLV_DEVTBL;
	rel_addr  = pi1_addr_i - DEVTBL_WBASE;
	if (pi1_addr_i >= INVALID_WBASE) begin
		dec_slave = pi1_pkg::SLV_INVALID;
		rel_addr  = pi1_addr_i - INVALID_WBASE;
	end else if (pi1_addr_i >= INTCTRL_WBASE) begin
		dec_slave = pi1_pkg::SLV_INTCTRL;
		rel_addr  = pi1_addr_i - INTCTRL_WBASE;
	end
end

// one staged cycle per request, then ready again
always_ff @(posedge clk120mhz) begin
	if (rst_i)
		busy <= 1'b0;
	else
		busy <= accept;
end

always_ff @(posedge clk120mhz) begin
	if (accept) begin
		stg_op_o     <= pi1_op_i;
		stg_slave_o  <= dec_slave;
		stg_offset_o <= pi1_pkg::offset_t'(rel_addr);
		stg_data_o   <= pi1_data_i;
		stg_sel_o    <= pi1_sel_i;
	end
end

// a staged request must release the bus on the following cycle
a_single_stage: assert property (@(posedge clk120mhz) disable iff (rst_i)
	stg_valid_o |=> !stg_valid_o);

endmodule

/* verilog/devtbl.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module devtbl (
	 input  logic              clk120mhz
	,input  logic              rst_i
	,input  logic              stg_valid_i
	,input  pi1_pkg::pi1_op_e  stg_op_i
	,input  pi1_pkg::slave_e   stg_slave_i
	,input  pi1_pkg::offset_t  stg_offset_i
	,input  pi1_pkg::word_t    stg_data_i
	,input  pi1_pkg::sel_t     stg_sel_i
	,output pi1_pkg::word_t    rd_data_o
	,output logic              rst0_o
	,output logic              rst1_o
);

// per slave entries, index order matches slave_e
localparam logic [`ARCHBITSZ-2:0] DEV_ID [`SOC_DEVCOUNT] = '{
	(`ARCHBITSZ-1)'(`DEVTBL_ID),
	(`ARCHBITSZ-1)'(`INTCTRL_ID),
	(`ARCHBITSZ-1)'(`INVALID_ID)
};
localparam logic DEV_USEINTR [`SOC_DEVCOUNT] = '{
	`DEVTBL_USEINTR,
	`INTCTRL_USEINTR,
	`INVALID_USEINTR
};
localparam pi1_pkg::word_t DEV_MAPSZ [`SOC_DEVCOUNT] = '{
	`DEVTBL_MAPSZ,
	`INTCTRL_MAPSZ,
	`INVALID_MAPSZ
};

logic [1:0] ctrl_q;
logic       ctrl_wr;

// only byte lane 0 carries the reset bits
assign ctrl_wr = stg_valid_i && (stg_slave_i == pi1_pkg::SLV_DEVTBL) &&
	(stg_offset_i == pi1_pkg::offset_t'(`DEVTBL_CTRL_WORD)) &&
	((stg_op_i == pi1_pkg::PI1_WR) || (stg_op_i == pi1_pkg::PI1_RW)) &&
	stg_sel_i[0];

always_ff @(posedge clk120mhz) begin
	if (rst_i)
		ctrl_q <= 2'b00;
	else if (ctrl_wr)
		ctrl_q <= stg_data_i[1:0];
end

assign rst0_o = ctrl_q[0];
assign rst1_o = ctrl_q[1];

// read side, the old control value is returned on rw
always_comb begin
	rd_data_o = '0;
	if (stg_offset_i == pi1_pkg::offset_t'(`DEVTBL_CTRL_WORD))
		rd_data_o = {{(`ARCHBITSZ-2){1'b0}}, ctrl_q};
	else if (stg_offset_i == pi1_pkg::offset_t'(`DEVTBL_COUNT_WORD))
		rd_data_o = pi1_pkg::word_t'(`SOC_DEVCOUNT);
	// two words per slave: useintr and id, then map size
	for (int i = 0; i < `SOC_DEVCOUNT; i++) begin
		if (stg_offset_i == pi1_pkg::offset_t'(`DEVTBL_ENTRY_WORD + 2*i))
			rd_data_o = {DEV_USEINTR[i], DEV_ID[i]};
		if (stg_offset_i == pi1_pkg::offset_t'(`DEVTBL_ENTRY_WORD + 2*i + 1))
			rd_data_o = DEV_MAPSZ[i];
	end
end

endmodule

/* verilog/intctrl.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module intctrl (
	 input  logic                  clk120mhz
	,input  logic                  rst_i
	,input  logic                  stg_valid_i
	,input  pi1_pkg::pi1_op_e      stg_op_i
	,input  pi1_pkg::slave_e       stg_slave_i
	,input  pi1_pkg::offset_t      stg_offset_i
	,output pi1_pkg::word_t        rd_data_o
	,input  soc_pkg::intsrc_t      intrqst_src_i
	,output soc_pkg::intsrc_t      intrdy_src_o
	,output logic                  intrqst_dst_o
	,input  logic                  intrdy_dst_i
);

soc_pkg::intsrc_t      pending_q;
soc_pkg::intsrc_t      take;
soc_pkg::intsrc_t      claim_mask;
soc_pkg::intc_state_e  state_q;
soc_pkg::intc_state_e  state_d;
logic                  rqst_q;
logic                  claim;
logic                  deliver;
pi1_pkg::word_t        claim_idx;

// a source stays blocked until its pending bit is claimed
assign intrdy_src_o = ~pending_q;
assign take         = intrqst_src_i & intrdy_src_o;

assign claim = stg_valid_i && (stg_slave_i == pi1_pkg::SLV_INTCTRL) &&
	(stg_offset_i == pi1_pkg::offset_t'(`INTCTRL_CLAIM_WORD)) &&
	((stg_op_i == pi1_pkg::PI1_RD) || (stg_op_i == pi1_pkg::PI1_RW));

// isolate the lowest pending bit
assign claim_mask = claim ? (pending_q & (-pending_q)) : '0;

always_comb begin
	claim_idx = '0;
	// walk down so the lowest index wins
	for (int i = `INTSRCCOUNT-1; i >= 0; i--) begin
		if (pending_q[i])
			claim_idx = pi1_pkg::word_t'(i);
	end
end

always_comb begin
	rd_data_o = '0;
	if (stg_offset_i == pi1_pkg::offset_t'(`INTCTRL_CLAIM_WORD))
		rd_data_o = (|pending_q) ? claim_idx : `INTCTRL_NONE;
end

assign deliver = (|pending_q) && intrdy_dst_i;

always_comb begin
	state_d = state_q;
	case (state_q)
		soc_pkg::INTC_IDLE:
			if (deliver)
				state_d = soc_pkg::INTC_DELIVER;
		// destination took it once its ready drops
		soc_pkg::INTC_DELIVER:
			if (!intrdy_dst_i)
				state_d = soc_pkg::INTC_WAIT_CLAIM;
		soc_pkg::INTC_WAIT_CLAIM:
			if (claim)
				state_d = soc_pkg::INTC_IDLE;
		default:
			state_d = soc_pkg::INTC_IDLE;
	endcase
end

always_ff @(posedge clk120mhz) begin
	if (rst_i) begin
		pending_q <= '0;
		state_q   <= soc_pkg::INTC_IDLE;
		rqst_q    <= 1'b0;
	end else begin
		pending_q <= (pending_q & ~claim_mask) | take;
		state_q   <= state_d;
		if ((state_q == soc_pkg::INTC_IDLE) && deliver)
			rqst_q <= 1'b1;
		else if (!intrdy_dst_i)
			rqst_q <= 1'b0;
	end
end

assign intrqst_dst_o = rqst_q;

// request flag must stay in step with the FSM and pending bits
a_rqst_valid: assert property (@(posedge clk120mhz) disable iff (rst_i)
	intrqst_dst_o |-> (|pending_q) || (state_q == soc_pkg::INTC_DELIVER));

endmodule

/* verilog/rst_sequencer.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module rst_sequencer (
	 input  logic  clk120mhz
	,input  logic  rst_p
	,input  logic  rst0_i
	,input  logic  rst1_i
	,output logic  sys_rst_o
);

logic [`RST_CNTR_BITSZ-1:0] rst_cntr;
logic                       pwroff_q;

// warm reset and cold reset both restart the count
always_ff @(posedge clk120mhz) begin
	if (rst_p || rst1_i)
		rst_cntr <= {`RST_CNTR_BITSZ{1'b1}};
	else if (|rst_cntr)
		rst_cntr <= rst_cntr - 1'b1;
end

// power-off holds the system until the board reset
always_ff @(posedge clk120mhz) begin
	if (rst_p)
		pwroff_q <= 1'b0;
	else if (rst0_i && !rst1_i)
		pwroff_q <= 1'b1;
end

assign sys_rst_o = rst_p || (|rst_cntr) || pwroff_q;

// power-off only leaves through rst_p and keeps reset asserted
a_pwroff_hold: assert property (@(posedge clk120mhz)
	pwroff_q && !rst_p |=> pwroff_q && sys_rst_o);

endmodule

/* verilog/pi1_rsp_mux.sv */
`timescale 1ns/1ps

module pi1_rsp_mux (
	 input  logic              clk120mhz
	,input  logic              rst_i
	,input  logic              stg_valid_i
	,input  pi1_pkg::pi1_op_e  stg_op_i
	,input  pi1_pkg::slave_e   stg_slave_i
	,input  pi1_pkg::word_t    devtbl_data_i
	,input  pi1_pkg::word_t    intctrl_data_i
	,output pi1_pkg::word_t    pi1_data_o
);

logic            rd_done;
pi1_pkg::word_t  sel_data;

assign rd_done = stg_valid_i &&
	((stg_op_i == pi1_pkg::PI1_RD) || (stg_op_i == pi1_pkg::PI1_RW));

// invalid device reads as zero
always_comb begin
	case (stg_slave_i)
		pi1_pkg::SLV_DEVTBL:  sel_data = devtbl_data_i;
		pi1_pkg::SLV_INTCTRL: sel_data = intctrl_data_i;
		default:              sel_data = '0;
	endcase
end

// held until the next read completes, writes leave it alone
always_ff @(posedge clk120mhz) begin
	if (rst_i)
		pi1_data_o <= '0;
	else if (rd_done)
		pi1_data_o <= sel_data;
end

endmodule

/* verilog/soc_core.sv */
`timescale 1ns/1ps

module soc_core (
	 input  logic              clk120mhz
	,input  logic              rst_p
	,input  pi1_pkg::pi1_op_e  pi1_op_i
	,input  pi1_pkg::waddr_t   pi1_addr_i
	,input  pi1_pkg::word_t    pi1_data_i
	,input  pi1_pkg::sel_t     pi1_sel_i
	,output pi1_pkg::word_t    pi1_data_o
	,output logic              pi1_rdy_o
	,input  soc_pkg::intsrc_t  intrqst_src_i
	,output soc_pkg::intsrc_t  intrdy_src_o
	,output logic              intrqst_dst_o
	,input  logic              intrdy_dst_i
	,output logic              rst_o
);

// staged request shared by the slaves and the read mux
logic              stg_valid;
pi1_pkg::pi1_op_e  stg_op;
pi1_pkg::slave_e   stg_slave;
pi1_pkg::offset_t  stg_offset;
pi1_pkg::word_t    stg_data;
pi1_pkg::sel_t     stg_sel;

pi1_pkg::word_t    devtbl_data;
pi1_pkg::word_t    intctrl_data;
logic              rst0;
logic              rst1;

pi1_decoder u_decoder (
	 .clk120mhz    (clk120mhz)
	,.rst_i        (rst_o)
	,.pi1_op_i     (pi1_op_i)
	,.pi1_addr_i   (pi1_addr_i)
	,.pi1_data_i   (pi1_data_i)
	,.pi1_sel_i    (pi1_sel_i)
	,.pi1_rdy_o    (pi1_rdy_o)
	,.stg_valid_o  (stg_valid)
	,.stg_op_o     (stg_op)
	,.stg_slave_o  (stg_slave)
	,.stg_offset_o (stg_offset)
	,.stg_data_o   (stg_data)
	,.stg_sel_o    (stg_sel)
);

devtbl u_devtbl (
	 .clk120mhz    (clk120mhz)
	,.rst_i        (rst_o)
	,.stg_valid_i  (stg_valid)
	,.stg_op_i     (stg_op)
	,.stg_slave_i  (stg_slave)
	,.stg_offset_i (stg_offset)
	,.stg_data_i   (stg_data)
	,.stg_sel_i    (stg_sel)
	,.rd_data_o    (devtbl_data)
	,.rst0_o       (rst0)
	,.rst1_o       (rst1)
);

intctrl u_intctrl (
	 .clk120mhz     (clk120mhz)
	,.rst_i         (rst_o)
	,.stg_valid_i   (stg_valid)
	,.stg_op_i      (stg_op)
	,.stg_slave_i   (stg_slave)
	,.stg_offset_i  (stg_offset)
	,.rd_data_o     (intctrl_data)
	,.intrqst_src_i (intrqst_src_i)
	,.intrdy_src_o  (intrdy_src_o)
	,.intrqst_dst_o (intrqst_dst_o)
	,.intrdy_dst_i  (intrdy_dst_i)
);

// system reset leaves through rst_o and feeds every block
rst_sequencer u_rst_seq (
	 .clk120mhz (clk120mhz)
	,.rst_p     (rst_p)
	,.rst0_i    (rst0)
	,.rst1_i    (rst1)
	,.sys_rst_o (rst_o)
);

pi1_rsp_mux u_rsp_mux (
	 .clk120mhz      (clk120mhz)
	,.rst_i          (rst_o)
	,.stg_valid_i    (stg_valid)
	,.stg_op_i       (stg_op)
	,.stg_slave_i    (stg_slave)
	,.devtbl_data_i  (devtbl_data)
	,.intctrl_data_i (intctrl_data)
	,.pi1_data_o     (pi1_data_o)
);

endmodule

/* tb/tb_soc_core.sv */
`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_soc_core;

// rough cycle cost of each directed test
localparam int RESET_CYCLES   = 25;
localparam int DEVTBL_CYCLES  = 220;
localparam int INVALID_CYCLES = 90;
localparam int INTR_CYCLES    = 30;
localparam int WARM_CYCLES    = 30;
localparam int PWROFF_CYCLES  = 135;
localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + DEVTBL_CYCLES + INVALID_CYCLES +
	INTR_CYCLES + WARM_CYCLES + PWROFF_CYCLES);
localparam int WAIT_LIMIT     = 40;

// word bases of the slaves derived from the byte map sizes
localparam int unsigned INTC_WBASE    = `DEVTBL_MAPSZ / (`ARCHBITSZ/8);
localparam int unsigned INVALID_WBASE = (`DEVTBL_MAPSZ + `INTCTRL_MAPSZ) / (`ARCHBITSZ/8);
localparam int unsigned DEVTBL_WORDS  = `DEVTBL_MAPSZ / (`ARCHBITSZ/8);

logic              clk120mhz;
logic              rst_p;
pi1_pkg::pi1_op_e  pi1_op_i;
pi1_pkg::waddr_t   pi1_addr_i;
pi1_pkg::word_t    pi1_data_i;
pi1_pkg::sel_t     pi1_sel_i;
pi1_pkg::word_t    pi1_data_o;
logic              pi1_rdy_o;
soc_pkg::intsrc_t  intrqst_src_i;
soc_pkg::intsrc_t  intrdy_src_o;
logic              intrqst_dst_o;
logic              intrdy_dst_i;
logic              rst_o;

int                cycle_cnt = 0;
int                err_cnt = 0;
logic [15:0]       lfsr_q = 16'd19953;

soc_core dut (.*);

initial begin
	clk120mhz = 1'b0;
	forever #50 clk120mhz = ~clk120mhz;
end

always @(posedge clk120mhz) begin
	cycle_cnt <= cycle_cnt + 1;
	if (cycle_cnt >= TIMEOUT_CYCLES) begin
		$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end
end

task automatic stop_run(input string why);
	err_cnt++;
	$display("%s", why);
	$display("Simulation FAILED");
	$fatal(1, "stopped at first error");
endtask

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp)
	else stop_run($sformatf("Error: %s expected 0x%08h, got 0x%08h", name, exp, got));
endtask

task automatic check_true(input bit cond, input string why);
	assert (cond)
	else stop_run(why);
endtask

// galois lfsr stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_q[0]};
		lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
	end
	return v;
endfunction

// starts on a falling edge and returns on the falling edge where ready is back
task automatic bus_access(input pi1_pkg::pi1_op_e op, input int unsigned addr,
	input logic [31:0] wdata, input logic [3:0] sel);
	int n;
	n = 0;
	while (!pi1_rdy_o && n < WAIT_LIMIT) begin
		@(negedge clk120mhz);
		n++;
	end
	check_true(pi1_rdy_o, "bus stayed busy before a new request");
	pi1_op_i   = op;
	pi1_addr_i = 30'(addr);
	pi1_data_i = wdata;
	pi1_sel_i  = sel;
	@(negedge clk120mhz);
	pi1_op_i = pi1_pkg::PI1_NOP;
	check_true(!pi1_rdy_o, "request was not accepted by the bus");
	n = 0;
	while (!pi1_rdy_o && n < WAIT_LIMIT) begin
		@(negedge clk120mhz);
		n++;
	end
	check_true(pi1_rdy_o, "pi1_rdy_o did not come back after a request");
endtask

task automatic bus_write(input int unsigned addr, input logic [31:0] wdata,
	input logic [3:0] sel);
	bus_access(pi1_pkg::PI1_WR, addr, wdata, sel);
endtask

task automatic bus_read(input int unsigned addr, input logic [31:0] exp);
	bus_access(pi1_pkg::PI1_RD, addr, '0, 4'h0);
	check_val("pi1_data_o", pi1_data_o, exp);
endtask

task automatic bus_rw(input int unsigned addr, input logic [31:0] wdata,
	input logic [31:0] exp_old);
	bus_access(pi1_pkg::PI1_RW, addr, wdata, 4'hF);
	check_val("pi1_data_o", pi1_data_o, exp_old);
endtask

// hold rst_p for 5 cycles and count edges until rst_o drops
task automatic apply_reset();
	int n;
	rst_p = 1'b1;
	repeat (5) @(negedge clk120mhz);
	rst_p = 1'b0;
	n = 0;
	while (rst_o && n < WAIT_LIMIT) begin
		@(negedge clk120mhz);
		n++;
	end
	check_true(n == 15, $sformatf("rst_o fell %0d edges after rst_p release, not 15", n));
	check_val("pi1_rdy_o", 32'(pi1_rdy_o), 32'h1);
	check_val("intrqst_dst_o", 32'(intrqst_dst_o), 32'h0);
	check_val("intrdy_src_o", 32'(intrdy_src_o), 32'h7);
	check_val("pi1_data_o", pi1_data_o, 32'h0);
endtask

task automatic check_entries();
	logic [31:0] id_w [`SOC_DEVCOUNT];
	logic [31:0] size_w [`SOC_DEVCOUNT];
	id_w[0]   = {`DEVTBL_USEINTR, (`ARCHBITSZ-1)'(`DEVTBL_ID)};
	id_w[1]   = {`INTCTRL_USEINTR, (`ARCHBITSZ-1)'(`INTCTRL_ID)};
	id_w[2]   = {`INVALID_USEINTR, (`ARCHBITSZ-1)'(`INVALID_ID)};
	size_w[0] = `DEVTBL_MAPSZ;
	size_w[1] = `INTCTRL_MAPSZ;
	size_w[2] = `INVALID_MAPSZ;
	bus_read(`DEVTBL_CTRL_WORD, 32'h0);
	bus_read(`DEVTBL_COUNT_WORD, `SOC_DEVCOUNT);
	for (int i = 0; i < `SOC_DEVCOUNT; i++) begin
		bus_read(`DEVTBL_ENTRY_WORD + 2*i, id_w[i]);
		bus_read(`DEVTBL_ENTRY_WORD + 2*i + 1, size_w[i]);
	end
endtask

task automatic test_devtbl();
	check_entries();
	for (int w = `DEVTBL_ENTRY_WORD + 2*`SOC_DEVCOUNT; w < DEVTBL_WORDS; w++)
		bus_read(w, 32'h0);
	bus_rw(`DEVTBL_CTRL_WORD, 32'h0, 32'h0);
	// byte lane 0 off so the reset bits must not change
	bus_write(`DEVTBL_CTRL_WORD, 32'h3, 4'hE);
	bus_read(`DEVTBL_CTRL_WORD, 32'h0);
	bus_read(INTC_WBASE + 1, 32'h0);
	check_val("rst_o", 32'(rst_o), 32'h0);
endtask

task automatic test_invalid();
	logic [31:0] r;
	logic [31:0] d;
	repeat (6) begin
		r = rand_bits(28);
		d = rand_bits(32);
		// load a non-zero value first so a stale result shows up
		bus_read(`DEVTBL_COUNT_WORD, `SOC_DEVCOUNT);
		bus_read(INVALID_WBASE + r, 32'h0);
		bus_write(INVALID_WBASE + r, d, 4'hF);
	end
	check_val("rst_o", 32'(rst_o), 32'h0);
	check_entries();
endtask

task automatic test_intr();
	logic [31:0] p;
	logic [2:0]  exp_rdy;
	int          n;
	p = '0;
	n = 0;
	while (p[2:0] == 3'b000 && n < 8) begin
		p = rand_bits(3);
		n++;
	end
	check_true(p[2:0] != 3'b000, "no non-zero interrupt pattern from the LFSR");
	intrdy_dst_i  = 1'b1;
	intrqst_src_i = p[2:0];
	@(negedge clk120mhz);
	intrqst_src_i = '0;
	exp_rdy = ~p[2:0];
	check_val("intrdy_src_o", 32'(intrdy_src_o), 32'(exp_rdy));
	n = 0;
	while (!intrqst_dst_o && n < WAIT_LIMIT) begin
		@(negedge clk120mhz);
		n++;
	end
	check_true(intrqst_dst_o, "intrqst_dst_o never rose for a pending interrupt");
	intrdy_dst_i = 1'b0;
	@(negedge clk120mhz);
	check_val("intrqst_dst_o", 32'(intrqst_dst_o), 32'h0);
	// claims come back lowest index first
	for (int i = 0; i < `INTSRCCOUNT; i++) begin
		if (p[i]) begin
			bus_read(INTC_WBASE + `INTCTRL_CLAIM_WORD, i);
			check_val($sformatf("intrdy_src_o[%0d]", i), 32'(intrdy_src_o[i]), 32'h1);
		end
	end
	bus_read(INTC_WBASE + `INTCTRL_CLAIM_WORD, `INTCTRL_NONE);
	check_val("intrdy_src_o", 32'(intrdy_src_o), 32'h7);
endtask

task automatic test_warm();
	int n;
	// leave every source pending so the warm reset has something to clear
	intrqst_src_i = '1;
	@(negedge clk120mhz);
	intrqst_src_i = '0;
	check_val("intrdy_src_o", 32'(intrdy_src_o), 32'h0);
	bus_rw(`DEVTBL_CTRL_WORD, 32'h2, 32'h0);
	check_val("rst_o", 32'(rst_o), 32'h0);
	n = 0;
	@(negedge clk120mhz);
	while (rst_o && n < WAIT_LIMIT) begin
		n++;
		@(negedge clk120mhz);
	end
	check_true(n == 16, $sformatf("warm reset held rst_o for %0d cycles, not 16", n));
	bus_read(`DEVTBL_CTRL_WORD, 32'h0);
	bus_read(INTC_WBASE + `INTCTRL_CLAIM_WORD, `INTCTRL_NONE);
	check_val("intrdy_src_o", 32'(intrdy_src_o), 32'h7);
endtask

task automatic test_pwroff();
	bus_write(`DEVTBL_CTRL_WORD, 32'h1, 4'h1);
	check_val("rst_o", 32'(rst_o), 32'h0);
	for (int i = 0; i < 100; i++) begin
		@(negedge clk120mhz);
		check_val("rst_o", 32'(rst_o), 32'h1);
	end
	// only the board reset brings the system back
	apply_reset();
	bus_read(`DEVTBL_COUNT_WORD, `SOC_DEVCOUNT);
endtask

initial begin
	rst_p         = 1'b1;
	pi1_op_i      = pi1_pkg::PI1_NOP;
	pi1_addr_i    = '0;
	pi1_data_i    = '0;
	pi1_sel_i     = '0;
	intrqst_src_i = '0;
	intrdy_dst_i  = 1'b0;
	apply_reset();
	test_devtbl();
	test_invalid();
	test_intr();
	test_warm();
	test_pwroff();
	if (err_cnt == 0) begin
		$display("Simulation PASSED");
	end else begin
		$display("Simulation FAILED");
	end
	$finish;
end

endmodule

/* list.f */
+incdir+verilog
verilog/pi1_pkg.sv
verilog/soc_pkg.sv
verilog/pi1_decoder.sv
verilog/devtbl.sv
verilog/intctrl.sv
verilog/rst_sequencer.sv
verilog/pi1_rsp_mux.sv
verilog/soc_core.sv
tb/tb_soc_core.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_soc_core
FILELIST = list.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)
